// File: project.f
src/spiPkg.sv
src/spiSlave.sv
src/cmdDecoder.sv
src/eventCounter.sv
src/spiCounterTop.sv
testbench/spiCounter_sva.sv
testbench/spiCounterTb.sv

// File: Makefile
TOP := spiCounterTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f project.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

// File: testbench/spiCounterTb.sv
`timescale 1ns/1ns

// drives the counter over bit-banged spi mode 0 and checks readbacks against a model
module spiCounterTb;
  import spiPkg::*;

  logic clk;
  logic rstN;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic eventIn;

  logic [15:0] lfsr = 16'd12;  // seed
  int strobeCnt = 0;           // rxValid pulses seen so far
  int checkCnt = 0;
  int errCount = 0;
  int testNum = 0;
  int testErrStart = 0;

  // reference model state
  logic [31:0] expCount = '0;
  logic        expEnabled = 1'b0;

  spiCounterTop #(
    .SyncStages(2)
  ) spiCounterTop_inst (
    .clk    (clk),
    .rstN   (rstN),
    .sck    (sck),
    .ssel   (ssel),
    .mosi   (mosi),
    .miso   (miso),
    .eventIn(eventIn)
  );

  bind spiCounterTop spiCounterSva svaInst (
    .clk    (clk),
    .rstN   (rstN),
    .ssel   (ssel),
    .rxValid(rxValid),
    .ctrl   (ctrl)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (spiCounterTop_inst.rxValid)
      strobeCnt <= strobeCnt + 1;
  end

  // maximal-length 16-bit galois lfsr
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  task automatic holdClk(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCnt++;
    if (got !== exp)
    begin
      errCount++;
      $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // strobes normally arrive inside the frame already
  task automatic waitStrobes(input int target);
    int waited = 0;
    while (strobeCnt < target && waited < 100)
    begin
      @(negedge clk);
      waited++;
    end
    if (strobeCnt < target)
    begin
      $display("timeout: no rxValid strobe for the last word after %0d clk", waited);
      $display("Test failures found");
      $finish;
    end
    else
      checkEq("rxValid count", strobeCnt, target);  // also catches extra strobes
  endtask

  // one frame of one or two words with miso sampled just before each rising sck
  task automatic spiFrame(input int nWords, input logic [31:0] w0, input logic [31:0] w1,
                          output logic [31:0] rd0, output logic [31:0] rd1);
    logic [63:0] txBits;
    logic [63:0] rxBits;
    int          target;
    txBits = {w0, w1};
    rxBits = '0;
    target = strobeCnt + nWords;
    ssel = 1'b0;
    mosi = txBits[63];
    holdClk(6);  // slave loads its snapshot meanwhile
    for (int i = 0; i < 32 * nWords; i++)
    begin
      rxBits = {rxBits[62:0], miso};
      sck = 1'b1;
      holdClk(6);
      sck = 1'b0;
      if (i + 1 < 32 * nWords)
        mosi = txBits[62-i];  // mode 0 data changes on the falling edge
      holdClk(6);
    end
    ssel = 1'b1;
    holdClk(6);
    waitStrobes(target);
    rd0 = (nWords == 2) ? rxBits[63:32] : rxBits[31:0];
    rd1 = (nWords == 2) ? rxBits[31:0] : 32'h0;
  endtask

  // toggles sck and mosi through a whole word with ssel held high
  task automatic strayClocks(input logic [31:0] w);
    for (int i = 0; i < 32; i++)
    begin
      mosi = w[31-i];
      holdClk(6);
      sck = 1'b1;
      holdClk(6);
      sck = 1'b0;
    end
    mosi = 1'b0;
    holdClk(6);
  endtask

  task automatic applyModel(input logic [31:0] w);
    case (w[31:24])
      cmdClear:   expCount = '0;
      cmdEnable:  expEnabled = 1'b1;
      cmdDisable: expEnabled = 1'b0;
      cmdLoad:    expCount = {8'h00, w[23:0]};
      default:    ;  // nop or unknown
    endcase
  endtask

  // readback shows the count from before this frame's command
  task automatic sendCommand(input logic [7:0] op, input logic [23:0] arg);
    logic [31:0] rd0;
    logic [31:0] rd1;
    spiFrame(1, {op, arg}, 32'h0, rd0, rd1);
    checkEq("miso readback", rd0, expCount);
    applyModel({op, arg});
  endtask

  task automatic pulseEvents(input int n);
    for (int i = 0; i < n; i++)
    begin
      eventIn = 1'b1;
      holdClk(6);
      eventIn = 1'b0;
      holdClk(6);
      if (expEnabled)
        expCount = expCount + 32'd1;
    end
    holdClk(10);  // last edge still in the synchronizer
  endtask

  task automatic finishTest(input string name);
    testNum++;
    $display("test %0d %s: %s", testNum, name, (errCount == testErrStart) ? "ok" : "FAILED");
    testErrStart = errCount;
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] rd0;
    logic [31:0] rd1;
    logic [7:0]  op;
    int          strobesBefore;
    rstN    = 1'b0;
    sck     = 1'b0;
    ssel    = 1'b1;
    mosi    = 1'b0;
    eventIn = 1'b0;
    holdClk(2);
    rstN = 1'b1;
    holdClk(2);

    sendCommand(cmdNop, 24'h0);
    finishTest("reset readback");

    sendCommand(cmdEnable, 24'h0);
    takeBits(5, r);
    pulseEvents(int'(r % 32'd20) + 1);
    sendCommand(cmdNop, 24'h0);
    finishTest("enable and count");

    sendCommand(cmdDisable, 24'h0);
    takeBits(5, r);
    pulseEvents(int'(r % 32'd20) + 1);  // model ignores them too
    sendCommand(cmdNop, 24'h0);
    finishTest("disable holds count");

    sendCommand(cmdClear, 24'h0);
    takeBits(24, r);
    sendCommand(cmdLoad, r[23:0]);   // readback here is the cleared 0
    sendCommand(cmdEnable, 24'h0);   // and here the loaded value
    takeBits(5, r);
    pulseEvents(int'(r % 32'd20) + 1);
    sendCommand(cmdNop, 24'h0);
    finishTest("clear and load");

    for (int k = 0; k < 4; k++)
    begin
      takeBits(8, r);
      op = r[7:0];
      if (op < 8'h05)
        op = op + 8'h05;  // keep clear of defined opcodes
      takeBits(24, r);
      sendCommand(op, r[23:0]);
    end
    takeBits(5, r);
    pulseEvents(int'(r % 32'd20) + 1);
    sendCommand(cmdNop, 24'h0);
    finishTest("unknown opcodes");

    // a clear word clocked in while deselected must not reach the decoder
    strobesBefore = strobeCnt;
    strayClocks({cmdClear, 24'h0});
    checkEq("rxValid count", strobeCnt, strobesBefore);
    sendCommand(cmdNop, 24'h0);
    finishTest("stray sck while deselected");

    // the loaded value only survives if clear comes first
    takeBits(24, r);
    spiFrame(2, {cmdClear, 24'h0}, {cmdLoad, r[23:0]}, rd0, rd1);
    checkEq("miso word 0", rd0, expCount);
    checkEq("miso word 1", rd1, 32'h0);
    applyModel({cmdClear, 24'h0});
    applyModel({cmdLoad, r[23:0]});
    sendCommand(cmdNop, 24'h0);
    finishTest("two-word frame");

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             testNum, checkCnt, errCount, spiCounterTop_inst.svaInst.failCount);
    if (errCount == 0 && spiCounterTop_inst.svaInst.failCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: testbench/spiCounter_sva.sv
`timescale 1ns/1ns

// strobe and control checks bound into the top level
module spiCounterSva (
  input logic          clk,
  input logic          rstN,
  input logic          ssel,
  input logic          rxValid,
  input spiPkg::ctrl_t ctrl
);

  int failCount = 0;  // read by the testbench at the end

  // words are 32 sck periods apart
  strobeSingle: assert property (@(posedge clk) disable iff (!rstN) rxValid |=> !rxValid)
    else
    begin
      failCount++;
      $error("rxValid high in two consecutive cycles");
    end

  ctrlOneHot: assert property (@(posedge clk) disable iff (!rstN)
      $onehot0({ctrl.clear, ctrl.enable, ctrl.disableCnt, ctrl.load}))
    else
    begin
      failCount++;
      $error("more than one ctrl flag high");
    end

  // ssel high long enough to clear the sync chain means no frame is open
  noStrobeIdle: assert property (@(posedge clk) disable iff (!rstN)
      (ssel && $past(ssel) && $past(ssel, 2) && $past(ssel, 3)) |-> !rxValid)
    else
    begin
      failCount++;
      $error("rxValid strobed while ssel is high");
    end

endmodule

// File: src/spiCounterTop.sv
`timescale 1ns/1ns

// spi-controlled event counter
// host writes commands and reads the count back in the same frame
module spiCounterTop #(
  parameter int SyncStages = 2  // sync depth for all async pins
) (
  input  logic clk,
  input  logic rstN,
  input  logic sck,
  input  logic ssel,     // active low
  input  logic mosi,
  output logic miso,
  input  logic eventIn
);
  import spiPkg::*;

  cmdWord_t             rxWord;   // slave -> decoder
  logic                 rxValid;
  ctrl_t                ctrl;     // decoder -> counter
  logic [wordWidth-1:0] count;    // counter -> slave readback

  spiSlave #(
    .SyncStages(SyncStages)
  ) slaveInst (
    .clk    (clk),
    .rstN   (rstN),
    .sck    (sck),
    .ssel   (ssel),
    .mosi   (mosi),
    .miso   (miso),
    .count  (count),
    .rxWord (rxWord),
    .rxValid(rxValid)
  );

  cmdDecoder decoderInst (
    .clk    (clk),
    .rstN   (rstN),
    .rxWord (rxWord),
    .rxValid(rxValid),
    .ctrl   (ctrl)
  );

  eventCounter #(
    .SyncStages(SyncStages)
  ) counterInst (
    .clk    (clk),
    .rstN   (rstN),
    .eventIn(eventIn),
    .ctrl   (ctrl),
    .count  (count)
  );

endmodule

// File: src/eventCounter.sv
`timescale 1ns/1ns

// counts rising edges of an asynchronous event pin
module eventCounter #(
  parameter int SyncStages = 2
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         eventIn,  // async to clk
  input  spiPkg::ctrl_t                ctrl,
  output logic [spiPkg::wordWidth-1:0] count
);
  import spiPkg::*;

  logic [SyncStages:0] eventSync;  // sync flops plus the edge-detect stage
  logic                eventRise;
  logic                enabled;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      eventSync <= '0;
    else
      eventSync <= {eventSync[SyncStages-1:0], eventIn};
  end

  // edge seen SyncStages clk after the pin, counted one clk later
  assign eventRise = (eventSync[SyncStages -: 2] == 2'b01);

  // enable flag, holds its value between commands
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      enabled <= 1'b0;
    else if (ctrl.enable)
      enabled <= 1'b1;
    else if (ctrl.disableCnt)
      enabled <= 1'b0;
  end

  // clear and load beat a simultaneous event
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      count <= '0;
    else if (ctrl.clear)
      count <= '0;
    else if (ctrl.load)
      count <= ctrl.loadValue;
    else if (enabled && eventRise)
      count <= count + wordWidth'(1);  // wraps at 2^32
  end

endmodule

// File: src/cmdDecoder.sv
`timescale 1ns/1ns

// turns each received word into a one-cycle control flag for the counter
module cmdDecoder (
  input  logic             clk,
  input  logic             rstN,
  input  spiPkg::cmdWord_t rxWord,
  input  logic             rxValid,
  output spiPkg::ctrl_t    ctrl
);
  import spiPkg::*;

  logic                 clearQ;
  logic                 enableQ;
  logic                 disableQ;
  logic                 loadQ;
  logic [wordWidth-1:0] loadValueQ;

  // flags drop back to zero the cycle after they fire
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      clearQ   <= 1'b0;
      enableQ  <= 1'b0;
      disableQ <= 1'b0;
      loadQ    <= 1'b0;
    end
    else
    begin
      clearQ   <= 1'b0;
      enableQ  <= 1'b0;
      disableQ <= 1'b0;
      loadQ    <= 1'b0;
      if (rxValid)
      begin
        case (rxWord.op)
          cmdClear:   clearQ   <= 1'b1;
          cmdEnable:  enableQ  <= 1'b1;
          cmdDisable: disableQ <= 1'b1;
          cmdLoad:    loadQ    <= 1'b1;
          default:    ;  // nop and unknown opcodes do nothing
        endcase
      end
    end
  end

  // load argument, zero-extended to the count width
  always_ff @(posedge clk)
  begin
    if (rxValid && rxWord.op == cmdLoad)
      loadValueQ <= {{(wordWidth-argWidth){1'b0}}, rxWord.arg};
  end

  assign ctrl = '{
    clear:      clearQ,
    enable:     enableQ,
    disableCnt: disableQ,
    load:       loadQ,
    loadValue:  loadValueQ
  };

endmodule

// File: src/spiSlave.sv
`timescale 1ns/1ns

// spi mode 0 slave, 32-bit words, everything sampled on clk
module spiSlave #(
  parameter int SyncStages = 2  // two or more
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         sck,
  input  logic                         ssel,   // active low
  input  logic                         mosi,
  output logic                         miso,
  input  logic [spiPkg::wordWidth-1:0] count,  // snapshot taken at frame start
  output spiPkg::cmdWord_t             rxWord,
  output logic                         rxValid
);
  import spiPkg::*;

  // sync chains for the pins, sck and ssel get one more stage for edge detection
  logic [SyncStages:0]   sckSync;
  logic [SyncStages:0]   sselSync;
  logic [SyncStages-1:0] mosiSync;

  logic sckRise;
  logic sckFall;
  logic sselActive;
  logic sselStart;
  logic mosiBit;

  logic [4:0]           bitCnt;   // wraps at 32, one word per turn
  logic [wordWidth-1:0] rxShift;  // receive shifter, MSB first
  logic [wordWidth-1:0] txShift;  // transmit shifter, MSB on miso

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      sckSync  <= '0;  // mode 0 idles low
      sselSync <= '1;  // deselected
    end
    else
    begin
      sckSync  <= {sckSync[SyncStages-1:0], sck};
      sselSync <= {sselSync[SyncStages-1:0], ssel};
    end
  end

  // mosi is data only, sampled when sck rises
  always_ff @(posedge clk)
  begin
    mosiSync <= {mosiSync[SyncStages-2:0], mosi};
  end

  // the top bit is the extra stage, the one below is the synced pin
  assign sckRise    = (sckSync[SyncStages -: 2] == 2'b01);
  assign sckFall    = (sckSync[SyncStages -: 2] == 2'b10);
  assign sselActive = ~sselSync[SyncStages-1];
  assign sselStart  = (sselSync[SyncStages -: 2] == 2'b10);  // frame starts at ssel fall
  assign mosiBit    = mosiSync[SyncStages-1];

  // bit counter, held at zero between frames
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      bitCnt <= '0;
    else if (!sselActive || sselStart)
      bitCnt <= '0;
    else if (sckRise)
      bitCnt <= bitCnt + 5'd1;  // 31 -> 0 starts the next word
  end

  always_ff @(posedge clk)
  begin
    if (sselActive && sckRise)
      rxShift <= {rxShift[wordWidth-2:0], mosiBit};  // shift left, MSB arrives first
  end

  // strobe after the rise that brought in bit 32
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      rxValid <= 1'b0;
    else
      rxValid <= sselActive && sckRise && (bitCnt == 5'd31);
  end

  assign rxWord = cmdWord_t'(rxShift);

  // readback: count snapshot first, then zeros for the rest of the frame
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      txShift <= '0;
    else if (sselActive)
    begin
      if (sselStart)
        txShift <= count;  // bit 31 is on miso before the first rise
      else if (sckFall)
      begin
        if (bitCnt == 5'd0)
          txShift <= '0;  // first word done
        else
          txShift <= {txShift[wordWidth-2:0], 1'b0};
      end
    end
  end

  // single slave on the bus, miso is never released
  assign miso = txShift[wordWidth-1];

endmodule

// File: src/spiPkg.sv
package spiPkg;

  // one spi transfer carries a whole command word, and the count has the same width
  localparam int wordWidth = 32;
  localparam int opWidth   = 8;                  // opcode byte at the top of the word
  localparam int argWidth  = wordWidth - opWidth; // 24-bit argument below it

  // command opcodes, anything else is ignored by the decoder
  typedef enum logic [opWidth-1:0] {
    cmdNop     = 8'h00,  // readback only
    cmdClear   = 8'h01,  // count to zero
    cmdEnable  = 8'h02,  // start counting events
    cmdDisable = 8'h03,  // stop counting, count is kept
    cmdLoad    = 8'h04   // count to zero-extended arg
  } cmdOp_e;

  // received word as seen by the decoder, MSB first on the wire
  typedef struct packed {
    cmdOp_e              op;   // bits 31:24
    logic [argWidth-1:0] arg;  // bits 23:0
  } cmdWord_t;

  // decoder to counter, one-cycle strobes
  // at most one flag is high in any cycle
  typedef struct packed {
    logic                 clear;
    logic                 enable;
    logic                 disableCnt;  // "disable" is a keyword
    logic                 load;
    logic [wordWidth-1:0] loadValue;   // only meaningful with load
  } ctrl_t;

endpackage
